//--- rtl/cnn_defines.svh
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// image geometry.
`define IMG_W 8 // pixels per row.
`define IMG_H 8 // rows per image.
`define IN_CH 3 // channels per input pixel.
`define OUT_CH 8 // filters, one per output channel.
`define KSIZE 3 // kernel side.
`define TAPS 27 // KSIZE*KSIZE*IN_CH weights per filter.

// arithmetic.
`define DATA_W 16 // pixel, weight, bias and result width.
`define ACC_W 40 // accumulator width.
`define FRAC_BITS 8 // fixed-point fraction bits.

// wishbone word address map.
`define WB_ADR_W 14 // word address width.
`define REG_CTRL 0 // control and status word.
`define REG_BIAS_BASE 8 // one word per filter.
`define REG_WGT_BASE 256 // filter*32 + tap*3 + channel.
`define REG_PIX_BASE 512 // pixel*4 + channel.
`define REG_RES_BASE 1024 // out_pixel*8 + channel.

`endif

//--- rtl/cnn_pkg.sv
`include "cnn_defines.svh"

package cnn_pkg;

	// one signed channel value: pixel, weight, bias or result.
	typedef logic signed [`DATA_W-1:0] sample_t;

	// all input channels of one pixel, channel 0 in the low bits.
	typedef logic [`IN_CH*`DATA_W-1:0] pixel_t;

	typedef logic signed [`ACC_W-1:0] acc_t; // mac accumulator.

	// one result per filter, filter 0 in the low bits.
	typedef logic [`OUT_CH*`DATA_W-1:0] out_vec_t;

	typedef logic [$clog2(`IMG_W*`IMG_H)-1:0] pix_idx_t; // input pixel index.
	typedef logic [$clog2((`IMG_W-2)*(`IMG_H-2))-1:0] res_idx_t; // output pixel index.

	typedef logic [31:0] wb_data_t; // bus data word.

	// window feeder states.
	typedef enum logic [1:0] {
		WIN_IDLE, // waiting for start.
		WIN_RUN, // issuing raster addresses.
		WIN_FLUSH // last pixel still in the read pipe.
	} win_state_t;

endpackage

//--- rtl/cnn_wb_regs.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module cnn_wb_regs (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [`WB_ADR_W-1:0]       wb_adr,
	input  cnn_pkg::wb_data_t          wb_dat_w,
	output cnn_pkg::wb_data_t          wb_dat_r,
	output logic                       wb_ack,
	output logic                       start,
	output logic                       wgt_we,
	output logic [$clog2(`OUT_CH)-1:0] wgt_filter,
	output logic [$clog2(`TAPS)-1:0]   wgt_tap,
	output cnn_pkg::sample_t           wgt_data,
	output logic                       bias_we,
	output logic [$clog2(`OUT_CH)-1:0] bias_filter,
	output cnn_pkg::sample_t           bias_data,
	input  cnn_pkg::pix_idx_t          pix_rd_addr,
	output cnn_pkg::pixel_t            pix_rd_data,
	input  logic                       res_we,
	input  cnn_pkg::res_idx_t          res_addr,
	input  cnn_pkg::out_vec_t          res_data,
	input  logic                       run_done
);
	localparam int NPIX = `IMG_W * `IMG_H; // input pixels.
	localparam int NRES = (`IMG_W - 2) * (`IMG_H - 2); // output pixels.
	localparam logic [`WB_ADR_W-1:0] CTRL_ADR = `WB_ADR_W'(`REG_CTRL);
	localparam logic [`WB_ADR_W-1:0] BIAS_BASE = `WB_ADR_W'(`REG_BIAS_BASE);
	localparam logic [`WB_ADR_W-1:0] BIAS_END = `WB_ADR_W'(`REG_BIAS_BASE + `OUT_CH);
	localparam logic [`WB_ADR_W-1:0] WGT_BASE = `WB_ADR_W'(`REG_WGT_BASE);
	localparam logic [`WB_ADR_W-1:0] WGT_END = `WB_ADR_W'(`REG_WGT_BASE + `OUT_CH * 32);
	localparam logic [`WB_ADR_W-1:0] PIX_BASE = `WB_ADR_W'(`REG_PIX_BASE);
	localparam logic [`WB_ADR_W-1:0] PIX_END = `WB_ADR_W'(`REG_PIX_BASE + NPIX * 4);
	localparam logic [`WB_ADR_W-1:0] RES_BASE = `WB_ADR_W'(`REG_RES_BASE);
	localparam logic [`WB_ADR_W-1:0] RES_END = `WB_ADR_W'(`REG_RES_BASE + NRES * `OUT_CH);

	logic                 req; // new access, ack not yet given.
	logic                 wr; // write strobe for this access.
	logic                 go; // accepted start request.
	logic                 busy;
	logic                 done;
	logic                 sel_ctrl;
	logic                 sel_bias;
	logic                 sel_wgt;
	logic                 sel_pix;
	logic                 sel_res;
	logic [`WB_ADR_W-1:0] bias_off;
	logic [`WB_ADR_W-1:0] wgt_off;
	logic [`WB_ADR_W-1:0] pix_off;
	logic [`WB_ADR_W-1:0] res_off;
	logic                 pix_ch_ok; // channel slot 3 of a pixel is a hole.
	cnn_pkg::wb_data_t    rd_word;

	cnn_pkg::sample_t  pix_mem [`IN_CH][NPIX]; // one bank per channel.
	cnn_pkg::out_vec_t res_mem [NRES]; // all channels of an output pixel per word.

	assign req = wb_cyc & wb_stb & ~wb_ack;
	assign wr = req & wb_we;

	// address decode.
	assign sel_ctrl = (wb_adr == CTRL_ADR);
	assign sel_bias = (wb_adr >= BIAS_BASE) && (wb_adr < BIAS_END);
	assign sel_wgt = (wb_adr >= WGT_BASE) && (wb_adr < WGT_END);
	assign sel_pix = (wb_adr >= PIX_BASE) && (wb_adr < PIX_END);
	assign sel_res = (wb_adr >= RES_BASE) && (wb_adr < RES_END);
	assign bias_off = wb_adr - BIAS_BASE;
	assign wgt_off = wb_adr - WGT_BASE;
	assign pix_off = wb_adr - PIX_BASE;
	assign res_off = wb_adr - RES_BASE;
	assign pix_ch_ok = (pix_off[1:0] < `IN_CH);
	assign go = wr & sel_ctrl & wb_dat_w[0] & ~busy; // start ignored while busy.

	// weight and bias broadcast, frozen during a run.
	assign wgt_we = wr & sel_wgt & ~busy & (wgt_off[4:0] < `TAPS); // taps 27..31 unused.
	assign wgt_filter = wgt_off[7:5];
	assign wgt_tap = wgt_off[4:0];
	assign wgt_data = wb_dat_w[`DATA_W-1:0];
	assign bias_we = wr & sel_bias & ~busy;
	assign bias_filter = bias_off[2:0];
	assign bias_data = wb_dat_w[`DATA_W-1:0];

	always_ff @(posedge clk)
	begin
		if (wr & sel_pix & pix_ch_ok & ~busy)
		begin
			pix_mem[pix_off[1:0]][pix_off[7:2]] <= wb_dat_w[`DATA_W-1:0]; // host port.
		end
		for (int c = 0; c < `IN_CH; c++)
		begin
			pix_rd_data[c*`DATA_W +: `DATA_W] <= pix_mem[c][pix_rd_addr]; // feeder port.
		end
		if (res_we)
		begin
			res_mem[res_addr] <= res_data; // drain writes a full pixel.
		end
	end

	// read mux, unmapped words read as zero.
	always_comb
	begin
		rd_word = '0;
		if (sel_ctrl)
		begin
			rd_word[1:0] = {done, busy};
		end
		else if (sel_pix & pix_ch_ok)
		begin
			rd_word[`DATA_W-1:0] = pix_mem[pix_off[1:0]][pix_off[7:2]];
		end
		else if (sel_res)
		begin
			rd_word[`DATA_W-1:0] = res_mem[res_off[8:3]][res_off[2:0]*`DATA_W +: `DATA_W];
		end
	end

	always_ff @(posedge clk)
	begin
		if (req)
		begin
			wb_dat_r <= rd_word; // valid with ack.
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_ack <= 1'b0;
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			wb_ack <= req; // single-cycle ack.
			start <= go;
			if (go)
			begin
				busy <= 1'b1;
				done <= 1'b0; // new run clears old done.
			end
			else if (run_done)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else $error("wb_ack high for two cycles.");

endmodule

//--- rtl/conv_window.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module conv_window (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  cnn_pkg::pixel_t          pix_rd_data,
	output cnn_pkg::pix_idx_t        pix_rd_addr,
	output logic                     win_valid,
	output logic [`TAPS*`DATA_W-1:0] win_data
);
	localparam int COL_W = $clog2(`IMG_W);
	localparam int ROW_W = $clog2(`IMG_H);
	localparam logic [COL_W-1:0] COL_LAST = COL_W'(`IMG_W - 1);
	localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(`IMG_H - 1);
	localparam int EDGE = `KSIZE - 1; // rows and columns before the first full window.
	localparam int PIX_BITS = `IN_CH * `DATA_W;

	cnn_pkg::win_state_t state;
	logic [COL_W-1:0]    col; // column of the address being issued.
	logic [ROW_W-1:0]    row;
	logic                data_v; // pix_rd_data holds a pixel of this run.
	logic [COL_W-1:0]    data_col; // position of the pixel on pix_rd_data.
	logic [ROW_W-1:0]    data_row;
	cnn_pkg::pixel_t     lbuf [EDGE][`IMG_W]; // line buffers, lbuf[0] is the newer row.
	cnn_pkg::pixel_t     win [`KSIZE][`KSIZE]; // [row][col], row 0 on top.

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= cnn_pkg::WIN_IDLE;
			pix_rd_addr <= '0;
			row <= '0;
			col <= '0;
			data_v <= 1'b0;
			win_valid <= 1'b0;
		end
		else
		begin
			data_v <= (state == cnn_pkg::WIN_RUN); // one cycle read latency.
			win_valid <= data_v && (data_row >= EDGE) && (data_col >= EDGE);
			case (state)
				cnn_pkg::WIN_IDLE:
				begin
					if (start)
					begin
						state <= cnn_pkg::WIN_RUN;
						pix_rd_addr <= '0;
						row <= '0;
						col <= '0;
					end
				end
				cnn_pkg::WIN_RUN:
				begin
					pix_rd_addr <= pix_rd_addr + 1'b1; // raster order.
					if (col == COL_LAST)
					begin
						col <= '0;
						if (row == ROW_LAST)
						begin
							state <= cnn_pkg::WIN_FLUSH; // last address issued.
						end
						else
						begin
							row <= row + 1'b1;
						end
					end
					else
					begin
						col <= col + 1'b1;
					end
				end
				cnn_pkg::WIN_FLUSH:
				begin
					if (!data_v)
					begin
						state <= cnn_pkg::WIN_IDLE; // last window leaves this cycle.
					end
				end
				default: state <= cnn_pkg::WIN_IDLE;
			endcase
		end
	end

	// window datapath, shifts one pixel per valid read.
	always_ff @(posedge clk)
	begin
		data_row <= row;
		data_col <= col;
		if (data_v)
		begin
			lbuf[0][0] <= pix_rd_data;
			for (int r = 1; r < EDGE; r++)
			begin
				lbuf[r][0] <= lbuf[r-1][`IMG_W-1]; // chain rows.
			end
			for (int r = 0; r < EDGE; r++)
			begin
				for (int i = 1; i < `IMG_W; i++)
				begin
					lbuf[r][i] <= lbuf[r][i-1];
				end
			end
			for (int ky = 0; ky < `KSIZE; ky++)
			begin
				for (int kx = 0; kx < EDGE; kx++)
				begin
					win[ky][kx] <= win[ky][kx+1]; // slide left.
				end
			end
			win[EDGE][EDGE] <= pix_rd_data; // current row enters bottom right.
			for (int ky = 0; ky < EDGE; ky++)
			begin
				win[ky][EDGE] <= lbuf[EDGE-1-ky][`IMG_W-1]; // same column, older rows.
			end
		end
	end

	// flatten as tap*IN_CH + channel, tap = ky*KSIZE + kx.
	always_comb
	begin
		for (int ky = 0; ky < `KSIZE; ky++)
		begin
			for (int kx = 0; kx < `KSIZE; kx++)
			begin
				win_data[(ky*`KSIZE+kx)*PIX_BITS +: PIX_BITS] = win[ky][kx];
			end
		end
	end

	valid_not_idle: assert property (@(posedge clk) disable iff (rst)
		win_valid |-> (state != cnn_pkg::WIN_IDLE))
		else $error("win_valid while feeder idle.");

endmodule

//--- rtl/conv_filter.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module conv_filter #(
	parameter int FILTER_ID = 0
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       wgt_we,
	input  logic [$clog2(`OUT_CH)-1:0] wgt_filter,
	input  logic [$clog2(`TAPS)-1:0]   wgt_tap,
	input  cnn_pkg::sample_t           wgt_data,
	input  logic                       bias_we,
	input  logic [$clog2(`OUT_CH)-1:0] bias_filter,
	input  cnn_pkg::sample_t           bias_data,
	input  logic                       win_valid,
	input  logic [`TAPS*`DATA_W-1:0]   win_data,
	output logic                       out_valid,
	output cnn_pkg::sample_t           out_sample
);
	localparam logic [$clog2(`OUT_CH)-1:0] MY_ID = $clog2(`OUT_CH)'(FILTER_ID);
	localparam cnn_pkg::acc_t SAT_MAX = cnn_pkg::acc_t'(2**(`DATA_W-1) - 1);
	localparam cnn_pkg::acc_t SAT_MIN = cnn_pkg::acc_t'(-(2**(`DATA_W-1)));

	cnn_pkg::sample_t wgt [`TAPS]; // this filter's weights.
	cnn_pkg::sample_t bias;
	cnn_pkg::sample_t pix [`TAPS]; // window unpacked per tap.
	cnn_pkg::acc_t    prod [`TAPS]; // stage 1 products.
	cnn_pkg::acc_t    sum;
	cnn_pkg::acc_t    scaled;
	cnn_pkg::sample_t sat;
	logic             prod_v;

	always_ff @(posedge clk)
	begin
		if (wgt_we && (wgt_filter == MY_ID))
		begin
			wgt[wgt_tap] <= wgt_data; // only our slice of the broadcast.
		end
		if (bias_we && (bias_filter == MY_ID))
		begin
			bias <= bias_data;
		end
	end

	always_comb
	begin
		for (int i = 0; i < `TAPS; i++)
		begin
			pix[i] = win_data[i*`DATA_W +: `DATA_W];
		end
	end

	always_ff @(posedge clk)
	begin
		if (win_valid)
		begin
			for (int i = 0; i < `TAPS; i++)
			begin
				prod[i] <= pix[i] * wgt[i]; // sign extended to acc width.
			end
		end
	end

	// stage 2, bias aligned to the product scale, then back to sample scale.
	always_comb
	begin
		sum = cnn_pkg::acc_t'(bias) <<< `FRAC_BITS;
		for (int i = 0; i < `TAPS; i++)
		begin
			sum = sum + prod[i];
		end
		scaled = sum >>> `FRAC_BITS; // arithmetic, truncates toward minus infinity.
		if (scaled > SAT_MAX)
			sat = SAT_MAX[`DATA_W-1:0];
		else if (scaled < SAT_MIN)
			sat = SAT_MIN[`DATA_W-1:0];
		else
			sat = scaled[`DATA_W-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (prod_v)
		begin
			out_sample <= sat;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			prod_v <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			prod_v <= win_valid;
			out_valid <= prod_v; // two cycles after win_valid.
		end
	end

endmodule

//--- rtl/result_pack.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module result_pack (
	input  logic              clk,
	input  logic              rst,
	input  logic              out_valid,
	input  cnn_pkg::out_vec_t out_samples,
	output logic              res_we,
	output cnn_pkg::res_idx_t res_addr,
	output cnn_pkg::out_vec_t res_data,
	output logic              run_done
);
	localparam cnn_pkg::res_idx_t LAST_IDX =
		cnn_pkg::res_idx_t'((`IMG_W - 2) * (`IMG_H - 2) - 1); // last output pixel.

	cnn_pkg::out_vec_t relu; // rectified channels.

	always_comb
	begin
		for (int c = 0; c < `OUT_CH; c++)
		begin
			if (out_samples[c*`DATA_W + `DATA_W - 1])
				relu[c*`DATA_W +: `DATA_W] = '0; // negative clamps to zero.
			else
				relu[c*`DATA_W +: `DATA_W] = out_samples[c*`DATA_W +: `DATA_W];
		end
	end

	always_ff @(posedge clk)
	begin
		if (out_valid)
		begin
			res_data <= relu;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			res_we <= 1'b0;
			res_addr <= '0;
			run_done <= 1'b0;
		end
		else
		begin
			res_we <= out_valid; // one cycle behind the filters.
			run_done <= 1'b0;
			if (res_we)
			begin
				if (res_addr == LAST_IDX)
				begin
					res_addr <= '0; // ready for the next run.
					run_done <= 1'b1;
				end
				else
				begin
					res_addr <= res_addr + 1'b1;
				end
			end
		end
	end

	addr_in_range: assert property (@(posedge clk) disable iff (rst)
		res_we |-> (res_addr <= LAST_IDX))
		else $error("result write past the last output pixel.");

endmodule

//--- rtl/cnn_layer_top.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module cnn_layer_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [`WB_ADR_W-1:0] wb_adr,
	input  cnn_pkg::wb_data_t    wb_dat_w,
	output cnn_pkg::wb_data_t    wb_dat_r,
	output logic                 wb_ack
);
	logic                       start;
	logic                       wgt_we;
	logic [$clog2(`OUT_CH)-1:0] wgt_filter;
	logic [$clog2(`TAPS)-1:0]   wgt_tap;
	cnn_pkg::sample_t           wgt_data;
	logic                       bias_we;
	logic [$clog2(`OUT_CH)-1:0] bias_filter;
	cnn_pkg::sample_t           bias_data;
	cnn_pkg::pix_idx_t          pix_rd_addr;
	cnn_pkg::pixel_t            pix_rd_data;
	logic                       win_valid;
	logic [`TAPS*`DATA_W-1:0]   win_data;
	logic [`OUT_CH-1:0]         out_valid; // filters run in lockstep.
	cnn_pkg::out_vec_t          out_samples;
	logic                       res_we;
	cnn_pkg::res_idx_t          res_addr;
	cnn_pkg::out_vec_t          res_data;
	logic                       run_done;

	cnn_wb_regs u_cnn_wb_regs (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.start(start),
		.wgt_we(wgt_we), .wgt_filter(wgt_filter), .wgt_tap(wgt_tap), .wgt_data(wgt_data),
		.bias_we(bias_we), .bias_filter(bias_filter), .bias_data(bias_data),
		.pix_rd_addr(pix_rd_addr), .pix_rd_data(pix_rd_data),
		.res_we(res_we), .res_addr(res_addr), .res_data(res_data),
		.run_done(run_done)
	);

	conv_window u_conv_window (
		.clk(clk), .rst(rst), .start(start),
		.pix_rd_data(pix_rd_data), .pix_rd_addr(pix_rd_addr),
		.win_valid(win_valid), .win_data(win_data)
	);

	for (genvar f = 0; f < `OUT_CH; f++)
	begin : g_filter
		conv_filter #(.FILTER_ID(f)) u_conv_filter (
			.clk(clk), .rst(rst),
			.wgt_we(wgt_we), .wgt_filter(wgt_filter), .wgt_tap(wgt_tap), .wgt_data(wgt_data),
			.bias_we(bias_we), .bias_filter(bias_filter), .bias_data(bias_data),
			.win_valid(win_valid), .win_data(win_data),
			.out_valid(out_valid[f]),
			.out_sample(out_samples[f*`DATA_W +: `DATA_W]) // channel f of the packed set.
		);
	end

	result_pack u_result_pack (
		.clk(clk), .rst(rst),
		.out_valid(out_valid[0]), .out_samples(out_samples),
		.res_we(res_we), .res_addr(res_addr), .res_data(res_data),
		.run_done(run_done)
	);

endmodule

//--- sim/tb_cnn_layer.sv
`timescale 1ns/1ns
`include "cnn_defines.svh"

module tb_cnn_layer;

	localparam int NPIX = `IMG_W * `IMG_H; // input pixels.
	localparam int OW = `IMG_W - 2; // output map width.
	localparam int OH = `IMG_H - 2;
	localparam int ACK_TIMEOUT = 16; // cycles to wait for wb_ack.
	localparam int RUN_TIMEOUT = 500; // status polls before giving up.
	localparam int NROWS = 5;

	typedef enum logic [1:0] {PIX_LFSR, PIX_RAMP, PIX_CONST} pix_pat_t;
	typedef enum logic [1:0] {WGT_LFSR, WGT_NEG, WGT_BIG} wgt_pat_t;
	typedef enum logic [1:0] {BIAS_LFSR, BIAS_NEG, BIAS_MAX} bias_mode_t;
	typedef enum logic [1:0] {EXP_EXACT, EXP_ZERO, EXP_SAT} chk_t;

	// one test case: stimulus patterns and the property of the results.
	typedef struct packed {
		pix_pat_t   pix;
		wgt_pat_t   wgt;
		bias_mode_t bias;
		chk_t       chk;
		logic       restart; // write start again while busy.
	} case_t;

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	logic [`WB_ADR_W-1:0] wb_adr;
	cnn_pkg::wb_data_t    wb_dat_w;
	cnn_pkg::wb_data_t    wb_dat_r;
	logic                 wb_ack;

	case_t       cases [NROWS];
	int          pix_val [NPIX][`IN_CH]; // model of the pixel memory.
	int          wgt_val [`OUT_CH][`TAPS];
	int          bias_val [`OUT_CH];
	logic [15:0] lfsr_state;

	always #20 clk = ~clk; // 40 ns period.

	cnn_layer_top u_cnn_layer_top (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	// galois form, taps 16 14 13 11.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic int draw_bits(input int nbits);
		int v;
		v = 0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state); // one step per bit.
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	function automatic int draw_signed(input int nbits);
		int v;
		v = draw_bits(nbits);
		if (v >= (1 << (nbits - 1)))
			v = v - (1 << nbits); // two's complement of nbits.
		return v;
	endfunction

	// expected channel f at output pixel (oy, ox), after saturation and relu.
	function automatic int ref_output(input int f, input int oy, input int ox);
		longint acc;
		longint scaled;
		acc = longint'(bias_val[f]) <<< `FRAC_BITS; // bias on the product scale.
		for (int ky = 0; ky < `KSIZE; ky++)
		begin
			for (int kx = 0; kx < `KSIZE; kx++)
			begin
				for (int ch = 0; ch < `IN_CH; ch++)
				begin
					acc = acc + longint'(pix_val[(oy + ky) * `IMG_W + ox + kx][ch])
						* longint'(wgt_val[f][(ky * `KSIZE + kx) * `IN_CH + ch]);
				end
			end
		end
		scaled = acc >>> `FRAC_BITS;
		if (scaled > 32767)
			scaled = 32767;
		else if (scaled < -32768)
			scaled = -32768;
		if (scaled < 0)
			scaled = 0; // relu.
		return int'(scaled);
	endfunction

	task automatic check_value(input string what, input int idx, input int exp, input int act);
		assert (act == exp)
		else
		begin
			$display("** Error at %0t ns: %s, index %0d, expected %0d, got %0d",
				$time, what, idx, exp, act);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_cond(input bit cond, input string what);
		assert (cond)
		else
		begin
			$display("%s", what);
			$display("TB FAILED");
			$fatal(1, "bus protocol failure");
		end
	endtask

	// one classic cycle, entered and left on a falling edge.
	task automatic bus_access(input logic we, input int adr, input int wdata, output int rdata);
		int waited;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = `WB_ADR_W'(adr);
		wb_dat_w = wdata;
		@(negedge clk);
		waited = 1;
		while (!wb_ack && waited < ACK_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		check_cond(wb_ack, "timeout while waiting for wb_ack.");
		check_cond(waited == 1, "wb_ack did not come one cycle after strobe.");
		rdata = wb_dat_r; // valid with ack.
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk);
		check_cond(!wb_ack, "wb_ack stayed high for more than one cycle.");
	endtask

	task automatic bus_write(input int adr, input int data);
		int unused;
		bus_access(1'b1, adr, data, unused);
	endtask

	task automatic bus_read(input int adr, output int data);
		bus_access(1'b0, adr, 0, data);
	endtask

	// fill the model memories from the row patterns and copy them to the DUT.
	task automatic load_case(input case_t tc);
		for (int p = 0; p < NPIX; p++)
		begin
			for (int ch = 0; ch < `IN_CH; ch++)
			begin
				case (tc.pix)
					PIX_LFSR: pix_val[p][ch] = draw_signed(11);
					PIX_RAMP: pix_val[p][ch] = 200 + 16 * (p * `IN_CH + ch);
					default: pix_val[p][ch] = 300;
				endcase
				bus_write(`REG_PIX_BASE + p * 4 + ch, pix_val[p][ch]);
			end
		end
		for (int f = 0; f < `OUT_CH; f++)
		begin
			for (int k = 0; k < `TAPS; k++)
			begin
				case (tc.wgt)
					WGT_LFSR: wgt_val[f][k] = draw_signed(10);
					WGT_NEG: wgt_val[f][k] = -1 - draw_bits(8); // strictly negative.
					default: wgt_val[f][k] = 20000 + draw_bits(10);
				endcase
				bus_write(`REG_WGT_BASE + f * 32 + k, wgt_val[f][k]);
			end
			case (tc.bias)
				BIAS_LFSR: bias_val[f] = draw_signed(12);
				BIAS_NEG: bias_val[f] = -1 - draw_bits(8);
				default: bias_val[f] = 32767;
			endcase
			bus_write(`REG_BIAS_BASE + f, bias_val[f]);
		end
	endtask

	task automatic wait_done(input int row);
		int st;
		int polls;
		polls = 1;
		bus_read(`REG_CTRL, st);
		while ((st & 2) == 0 && polls < RUN_TIMEOUT)
		begin
			bus_read(`REG_CTRL, st);
			polls++;
		end
		check_cond((st & 2) != 0, "timeout while waiting for the done status.");
		check_value("status at end of run", row, 2, st); // done set, busy clear.
	endtask

	task automatic run_case(input case_t tc, input int row);
		int st;
		int rd;
		int exp;
		int idx;
		load_case(tc);
		bus_read(`REG_CTRL, st);
		check_value("status before start", row, (row == 0) ? 0 : 2, st);
		bus_write(`REG_CTRL, 1);
		bus_read(`REG_CTRL, st);
		check_value("status after start", row, 1, st); // old done cleared.
		if (tc.restart)
		begin
			bus_write(`REG_CTRL, 1); // dropped, engine busy.
			bus_write(`REG_PIX_BASE + (NPIX - 1) * 4, 12345); // last pixel, not yet read.
			bus_write(`REG_WGT_BASE, 12345);
			bus_read(`REG_CTRL, st);
			check_value("status after start while busy", row, 1, st);
		end
		wait_done(row);
		for (int oy = 0; oy < OH; oy++)
		begin
			for (int ox = 0; ox < OW; ox++)
			begin
				for (int f = 0; f < `OUT_CH; f++)
				begin
					idx = (oy * OW + ox) * `OUT_CH + f; // bus result index.
					bus_read(`REG_RES_BASE + idx, rd);
					exp = ref_output(f, oy, ox);
					check_value("result", idx, exp, rd);
					if (tc.chk == EXP_ZERO)
						check_value("result after relu", idx, 0, rd);
					else if (tc.chk == EXP_SAT)
						check_value("saturated result", idx, 32767, rd);
				end
			end
		end
	endtask

	initial
	begin
		int st;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		lfsr_state = 16'd62;
		cases[0] = '{PIX_LFSR, WGT_LFSR, BIAS_LFSR, EXP_EXACT, 1'b0};
		cases[1] = '{PIX_CONST, WGT_NEG, BIAS_NEG, EXP_ZERO, 1'b0};
		cases[2] = '{PIX_RAMP, WGT_BIG, BIAS_MAX, EXP_SAT, 1'b0};
		cases[3] = '{PIX_LFSR, WGT_LFSR, BIAS_LFSR, EXP_EXACT, 1'b1};
		cases[4] = '{PIX_RAMP, WGT_LFSR, BIAS_LFSR, EXP_EXACT, 1'b0}; // new pixels, same flow.
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		bus_read(`REG_CTRL, st);
		check_value("status after reset", 0, 0, st);
		for (int i = 0; i < NROWS; i++)
		begin
			run_case(cases[i], i);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- build.f
+incdir+rtl
rtl/cnn_pkg.sv
rtl/cnn_wb_regs.sv
rtl/conv_window.sv
rtl/conv_filter.sv
rtl/result_pack.sv
rtl/cnn_layer_top.sv
sim/tb_cnn_layer.sv

//--- Makefile
# Verilator build and run for the CNN layer testbench.

VERILATOR  ?= verilator
TOP        ?= tb_cnn_layer
LINT_TOP   ?= cnn_layer_top
BUILD_DIR  ?= obj_dir
FLIST      ?= build.f
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
